// File: logic/gpio_control.sv
`timescale 1ns/1ps
/* Team-select register that routes one team's GPIO outputs and enables to the pads.
   Select 0 or any index above NUM_TEAMS gives the idle default. */
module gpio_control #(
    parameter int NUM_TEAMS = 1
) (
    input  logic                                           wb_clk_i,
    input  logic                                           reset_i,
    wb_periph_if.peripheral                                bus,
    input  logic [nebula_pkg::GPIO_W*(NUM_TEAMS+1)-1:0]    designs_gpio_out_flat_i,
    input  logic [nebula_pkg::GPIO_W*(NUM_TEAMS+1)-1:0]    designs_gpio_oeb_flat_i,
    output logic [nebula_pkg::GPIO_W-1:0]                  gpio_out_o,
    output logic [nebula_pkg::GPIO_W-1:0]                  gpio_oeb_o
);
    logic [nebula_pkg::WB_DW-1:0] team_sel_q;
    logic [nebula_pkg::WB_DW-1:0] team_idx;
    logic                         access;
    logic                         reg_hit;

    assign access  = bus.cyc && bus.stb && !bus.ack;
    assign reg_hit = (bus.adr[3:2] == 2'b00);  // Select lives at offset 0

    // Out-of-range select falls back to slice 0
    assign team_idx = (team_sel_q <= NUM_TEAMS) ? team_sel_q : '0;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            bus.ack    <= 1'b0;
            team_sel_q <= '0;
        end else begin
            bus.ack <= access;
            if (access && bus.we && reg_hit)
                team_sel_q <= bus.dat_w;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            bus.dat_r <= reg_hit ? team_sel_q : '0;
    end

    // Pads registered behind the mux
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            gpio_out_o <= '0;
            gpio_oeb_o <= '1;  // All outputs disabled
        end else begin
            gpio_out_o <= designs_gpio_out_flat_i[team_idx*nebula_pkg::GPIO_W +: nebula_pkg::GPIO_W];
            gpio_oeb_o <= designs_gpio_oeb_flat_i[team_idx*nebula_pkg::GPIO_W +: nebula_pkg::GPIO_W];
        end
    end

endmodule

// File: logic/la_control.sv
`timescale 1ns/1ps
/* Team-select register that routes one team's logic-analyzer outputs out. */
module la_control #(
    parameter int NUM_TEAMS = 1
) (
    input  logic                                       wb_clk_i,
    input  logic                                       reset_i,
    wb_periph_if.peripheral                            bus,
    input  logic [nebula_pkg::LA_W*(NUM_TEAMS+1)-1:0]  designs_la_data_out_flat_i,
    output logic [nebula_pkg::LA_W-1:0]                la_data_out_o
);
    logic [nebula_pkg::WB_DW-1:0] team_sel_q;
    logic [nebula_pkg::WB_DW-1:0] team_idx;
    logic                         access;
    logic                         reg_hit;

    assign access   = bus.cyc && bus.stb && !bus.ack;
    assign reg_hit  = (bus.adr[3:2] == 2'b00);
    assign team_idx = (team_sel_q <= NUM_TEAMS) ? team_sel_q : '0;  // Same fallback as GPIO

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            bus.ack       <= 1'b0;
            team_sel_q    <= '0;
            la_data_out_o <= '0;
        end else begin
            bus.ack <= access;
            if (access && bus.we && reg_hit)
                team_sel_q <= bus.dat_w;
            la_data_out_o <= designs_la_data_out_flat_i[team_idx*nebula_pkg::LA_W +: nebula_pkg::LA_W];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            bus.dat_r <= reg_hit ? team_sel_q : '0;
    end

endmodule

// File: logic/nebula_pkg.sv
/* Shared address map, bus widths and enums for the user-area subsystem.
   Referenced by scoped name from the RTL, the interface and the bench. */
package nebula_pkg;

    // Wishbone widths
    localparam int WB_AW = 32;
    localparam int WB_DW = 32;
    localparam int WB_SW = 4;

    localparam int GPIO_W = 38;   // Caravel pads
    localparam int LA_W   = 128;  // Logic analyzer lines

    // Top address byte of the user area
    localparam logic [7:0] USER_BASE = 8'h30;

    // Target slave, picked by adr[17:16] inside the user area
    typedef enum logic [2:0] {
        PERIPH_SRAM = 3'd0,
        PERIPH_GPIO = 3'd1,
        PERIPH_LA   = 3'd2,
        PERIPH_TEAM = 3'd3,
        PERIPH_NONE = 3'd4
    } periph_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_ACCESS,
        DEC_DONE
    } dec_state_e;

    localparam logic [WB_DW-1:0] UNMAPPED_DATA = '0;  // Read value off the map

endpackage

// File: logic/nebula_top.sv
`timescale 1ns/1ps
/* User-area top: Wishbone decoder, SRAM, GPIO and LA routing plus the team designs.
   Team slot 0 is the idle default; team designs start at slot 1. */
module nebula_top (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    input  logic                          wbs_cyc_i,
    input  logic                          wbs_stb_i,
    input  logic                          wbs_we_i,
    input  logic [nebula_pkg::WB_SW-1:0]  wbs_sel_i,
    input  logic [nebula_pkg::WB_AW-1:0]  wbs_adr_i,
    input  logic [nebula_pkg::WB_DW-1:0]  wbs_dat_i,
    output logic                          wbs_ack_o,
    output logic [nebula_pkg::WB_DW-1:0]  wbs_dat_o,
    input  logic [nebula_pkg::LA_W-1:0]   la_data_in_i,
    output logic [nebula_pkg::LA_W-1:0]   la_data_out_o,
    input  logic [nebula_pkg::GPIO_W-1:0] io_in_i,
    output logic [nebula_pkg::GPIO_W-1:0] io_out_o,
    output logic [nebula_pkg::GPIO_W-1:0] io_oeb_o
);
    localparam int NUM_TEAMS = 1;

    // Per-team outputs, slot 0 is the default
    logic [nebula_pkg::GPIO_W-1:0] designs_gpio_out    [NUM_TEAMS:0];
    logic [nebula_pkg::GPIO_W-1:0] designs_gpio_oeb    [NUM_TEAMS:0];
    logic [nebula_pkg::LA_W-1:0]   designs_la_data_out [NUM_TEAMS:0];

    logic [nebula_pkg::GPIO_W*(NUM_TEAMS+1)-1:0] designs_gpio_out_flat;
    logic [nebula_pkg::GPIO_W*(NUM_TEAMS+1)-1:0] designs_gpio_oeb_flat;
    logic [nebula_pkg::LA_W*(NUM_TEAMS+1)-1:0]   designs_la_data_out_flat;

    wb_periph_if sram_bus ();
    wb_periph_if gpio_bus ();
    wb_periph_if la_bus ();
    wb_periph_if team_bus ();

    assign designs_gpio_out[0]    = '0;
    assign designs_gpio_oeb[0]    = '1;  // Active-low enables, all off
    assign designs_la_data_out[0] = '0;

    generate
        // Slots with no design yet behave like slot 0
        for (genvar t = 2; t <= NUM_TEAMS; t++) begin : g_idle
            assign designs_gpio_out[t]    = '0;
            assign designs_gpio_oeb[t]    = '1;
            assign designs_la_data_out[t] = '0;
        end
        for (genvar t = 0; t <= NUM_TEAMS; t++) begin : g_flat
            assign designs_gpio_out_flat[t*nebula_pkg::GPIO_W +: nebula_pkg::GPIO_W] =
                designs_gpio_out[t];
            assign designs_gpio_oeb_flat[t*nebula_pkg::GPIO_W +: nebula_pkg::GPIO_W] =
                designs_gpio_oeb[t];
            assign designs_la_data_out_flat[t*nebula_pkg::LA_W +: nebula_pkg::LA_W] =
                designs_la_data_out[t];
        end
    endgenerate

    wishbone_decoder wb_decoder (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .sram_bus  (sram_bus.manager),
        .gpio_bus  (gpio_bus.manager),
        .la_bus    (la_bus.manager),
        .team_bus  (team_bus.manager)
    );

    wb_sram sram (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .bus      (sram_bus.peripheral)
    );

    gpio_control #(
        .NUM_TEAMS(NUM_TEAMS)
    ) gpio_ctrl (
        .wb_clk_i                (wb_clk_i),
        .reset_i                 (reset_i),
        .bus                     (gpio_bus.peripheral),
        .designs_gpio_out_flat_i (designs_gpio_out_flat),
        .designs_gpio_oeb_flat_i (designs_gpio_oeb_flat),
        .gpio_out_o              (io_out_o),
        .gpio_oeb_o              (io_oeb_o)
    );

    la_control #(
        .NUM_TEAMS(NUM_TEAMS)
    ) la_ctrl (
        .wb_clk_i                   (wb_clk_i),
        .reset_i                    (reset_i),
        .bus                        (la_bus.peripheral),
        .designs_la_data_out_flat_i (designs_la_data_out_flat),
        .la_data_out_o              (la_data_out_o)
    );

    sample_team_proj team1 (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .bus           (team_bus.peripheral),
        .la_data_in_i  (la_data_in_i),
        .gpio_in_i     (io_in_i),
        .la_data_out_o (designs_la_data_out[1]),
        .gpio_out_o    (designs_gpio_out[1]),
        .gpio_oeb_o    (designs_gpio_oeb[1])
    );

endmodule

// File: logic/sample_team_proj.sv
`timescale 1ns/1ps
/* Sample team design with pattern, output-enable and LA-mask registers.
   Offset 12 reads back the upper pads as seen on io_in. */
module sample_team_proj (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    wb_periph_if.peripheral               bus,
    input  logic [nebula_pkg::LA_W-1:0]   la_data_in_i,
    input  logic [nebula_pkg::GPIO_W-1:0] gpio_in_i,
    output logic [nebula_pkg::LA_W-1:0]   la_data_out_o,
    output logic [nebula_pkg::GPIO_W-1:0] gpio_out_o,
    output logic [nebula_pkg::GPIO_W-1:0] gpio_oeb_o
);
    logic [nebula_pkg::WB_DW-1:0] pattern_q;
    logic [nebula_pkg::WB_DW-1:0] oeb_q;
    logic [nebula_pkg::WB_DW-1:0] la_mask_q;
    logic                         access;

    assign access = bus.cyc && bus.stb && !bus.ack;

    // Pads 5:0 stay inputs
    assign gpio_out_o    = {pattern_q, 6'b0};
    assign gpio_oeb_o    = {oeb_q, 6'h3f};
    assign la_data_out_o = la_data_in_i ^ {4{la_mask_q}};

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            bus.ack   <= 1'b0;
            pattern_q <= '0;
            oeb_q     <= '1;
            la_mask_q <= '0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                case (bus.adr[3:2])
                    2'd0: pattern_q <= bus.dat_w;
                    2'd1: oeb_q     <= bus.dat_w;
                    2'd2: la_mask_q <= bus.dat_w;
                    default: ;  // Input sample is read-only
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            case (bus.adr[3:2])
                2'd0: bus.dat_r <= pattern_q;
                2'd1: bus.dat_r <= oeb_q;
                2'd2: bus.dat_r <= la_mask_q;
                default: bus.dat_r <= gpio_in_i[37:6];
            endcase
        end
    end

endmodule

// File: logic/wb_periph_if.sv
`timescale 1ns/1ps
/* Slave-side Wishbone link, one instance per peripheral.
   The decoder holds the manager end, the slave the peripheral end. */
interface wb_periph_if;

    logic                         cyc;
    logic                         stb;
    logic                         we;
    logic [nebula_pkg::WB_AW-1:0] adr;
    logic [nebula_pkg::WB_DW-1:0] dat_w;
    logic [nebula_pkg::WB_SW-1:0] sel;
    logic                         ack;    // Single-cycle, registered in the slave
    logic [nebula_pkg::WB_DW-1:0] dat_r;  // Valid with ack

    modport manager (
        output cyc, stb, we, adr, dat_w, sel,
        input  ack, dat_r
    );

    modport peripheral (
        input  cyc, stb, we, adr, dat_w, sel,
        output ack, dat_r
    );

endinterface

// File: logic/wb_sram.sv
`timescale 1ns/1ps
/* 1024x32 word memory on a Wishbone slave link, byte lanes written per sel. */
module wb_sram (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    wb_periph_if.peripheral bus
);
    localparam int DEPTH = 1024;

    logic [nebula_pkg::WB_DW-1:0] mem [0:DEPTH-1];
    logic [9:0]                   word_adr;
    logic                         access;

    assign word_adr = bus.adr[11:2];  // Byte address to word index
    assign access   = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i)
            bus.ack <= 1'b0;
        else
            bus.ack <= access;
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < nebula_pkg::WB_SW; b++) begin
                    if (bus.sel[b])
                        mem[word_adr][8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
            bus.dat_r <= mem[word_adr];  // Old word on a write cycle
        end
    end

endmodule

// File: logic/wishbone_decoder.sv
`timescale 1ns/1ps
/* Latches one classic Wishbone request from the SoC, replays it to the addressed
   slave and returns that slave's data; unmapped addresses are acked locally. */
module wishbone_decoder (
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    input  logic                         wbs_cyc_i,
    input  logic                         wbs_stb_i,
    input  logic                         wbs_we_i,
    input  logic [nebula_pkg::WB_SW-1:0] wbs_sel_i,
    input  logic [nebula_pkg::WB_AW-1:0] wbs_adr_i,
    input  logic [nebula_pkg::WB_DW-1:0] wbs_dat_i,
    output logic                         wbs_ack_o,
    output logic [nebula_pkg::WB_DW-1:0] wbs_dat_o,
    wb_periph_if.manager                 sram_bus,
    wb_periph_if.manager                 gpio_bus,
    wb_periph_if.manager                 la_bus,
    wb_periph_if.manager                 team_bus
);
    nebula_pkg::dec_state_e       state_q;
    nebula_pkg::periph_e          target_q;
    logic [nebula_pkg::WB_AW-1:0] adr_q;
    logic [nebula_pkg::WB_DW-1:0] dat_q;
    logic [nebula_pkg::WB_SW-1:0] sel_q;
    logic                         we_q;
    logic                         none_ack_q;  // Stand-in slave ack when off the map
    logic                         access;
    logic                         request;
    logic                         slave_ack;
    logic [nebula_pkg::WB_DW-1:0] slave_dat;

    function automatic nebula_pkg::periph_e decode(input logic [nebula_pkg::WB_AW-1:0] adr);
        if (adr[nebula_pkg::WB_AW-1 -: 8] != nebula_pkg::USER_BASE)
            return nebula_pkg::PERIPH_NONE;
        return nebula_pkg::periph_e'({1'b0, adr[17:16]});
    endfunction

    assign request   = (state_q == nebula_pkg::DEC_IDLE) && wbs_cyc_i && wbs_stb_i;
    assign access    = (state_q == nebula_pkg::DEC_ACCESS);
    assign wbs_ack_o = (state_q == nebula_pkg::DEC_DONE);  // One cycle only

    // Only the addressed slave sees cyc/stb
    assign sram_bus.cyc = access && (target_q == nebula_pkg::PERIPH_SRAM);
    assign sram_bus.stb = access && (target_q == nebula_pkg::PERIPH_SRAM);
    assign gpio_bus.cyc = access && (target_q == nebula_pkg::PERIPH_GPIO);
    assign gpio_bus.stb = access && (target_q == nebula_pkg::PERIPH_GPIO);
    assign la_bus.cyc   = access && (target_q == nebula_pkg::PERIPH_LA);
    assign la_bus.stb   = access && (target_q == nebula_pkg::PERIPH_LA);
    assign team_bus.cyc = access && (target_q == nebula_pkg::PERIPH_TEAM);
    assign team_bus.stb = access && (target_q == nebula_pkg::PERIPH_TEAM);

    // Payload is shared, qualified by stb
    assign sram_bus.we    = we_q;
    assign sram_bus.adr   = adr_q;
    assign sram_bus.dat_w = dat_q;
    assign sram_bus.sel   = sel_q;
    assign gpio_bus.we    = we_q;
    assign gpio_bus.adr   = adr_q;
    assign gpio_bus.dat_w = dat_q;
    assign gpio_bus.sel   = sel_q;
    assign la_bus.we      = we_q;
    assign la_bus.adr     = adr_q;
    assign la_bus.dat_w   = dat_q;
    assign la_bus.sel     = sel_q;
    assign team_bus.we    = we_q;
    assign team_bus.adr   = adr_q;
    assign team_bus.dat_w = dat_q;
    assign team_bus.sel   = sel_q;

    always_comb begin
        case (target_q)
            nebula_pkg::PERIPH_SRAM: begin
                slave_ack = sram_bus.ack;
                slave_dat = sram_bus.dat_r;
            end
            nebula_pkg::PERIPH_GPIO: begin
                slave_ack = gpio_bus.ack;
                slave_dat = gpio_bus.dat_r;
            end
            nebula_pkg::PERIPH_LA: begin
                slave_ack = la_bus.ack;
                slave_dat = la_bus.dat_r;
            end
            nebula_pkg::PERIPH_TEAM: begin
                slave_ack = team_bus.ack;
                slave_dat = team_bus.dat_r;
            end
            default: begin
                slave_ack = none_ack_q;
                slave_dat = nebula_pkg::UNMAPPED_DATA;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q    <= nebula_pkg::DEC_IDLE;
            target_q   <= nebula_pkg::PERIPH_NONE;
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= 1'b0;
            case (state_q)
                nebula_pkg::DEC_IDLE: begin
                    if (request) begin
                        target_q <= decode(wbs_adr_i);
                        state_q  <= nebula_pkg::DEC_ACCESS;
                    end
                end
                nebula_pkg::DEC_ACCESS: begin
                    // Mimic a slave answering one cycle after its strobe
                    none_ack_q <= (target_q == nebula_pkg::PERIPH_NONE) && !none_ack_q;
                    if (slave_ack)
                        state_q <= nebula_pkg::DEC_DONE;
                end
                default: state_q <= nebula_pkg::DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (request) begin
            adr_q <= wbs_adr_i;
            dat_q <= wbs_dat_i;
            sel_q <= wbs_sel_i;
            we_q  <= wbs_we_i;
        end
        if (access && slave_ack)
            wbs_dat_o <= slave_dat;  // Held through the ack cycle
    end

endmodule

// File: project.f
logic/nebula_pkg.sv
logic/wb_periph_if.sv
logic/wishbone_decoder.sv
logic/gpio_control.sv
logic/la_control.sv
logic/wb_sram.sv
logic/sample_team_proj.sv
logic/nebula_top.sv
testbench/nebula_sva.sv
testbench/nebula_tb.sv

// File: run.sh
#!/bin/sh
# Compile the design and testbench with Verilator, then run the simulation.
# The exit status is non-zero when the testbench or an assertion fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module nebula_tb -f project.f -o nebula_sim

./obj_dir/nebula_sim

// File: testbench/nebula_sva.sv
`timescale 1ns/1ps
/* Concurrent checks on the decoder handshake and FSM, attached by bind. */
module nebula_sva (
    input logic                   wb_clk_i,
    input logic                   reset_i,
    input logic                   wbs_cyc_i,
    input logic                   wbs_ack_i,
    input nebula_pkg::dec_state_e state_i,
    input logic [3:0]             strobes_i  // {team, la, gpio, sram}
);

    ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        wbs_ack_i |=> !wbs_ack_i)
        else $error("wbs_ack_o stayed high for two cycles");

    ack_inside_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        wbs_ack_i |-> wbs_cyc_i)
        else $error("wbs_ack_o high while wbs_cyc_i is low");

    single_strobe: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $onehot0(strobes_i))
        else $error("More than one slave strobe high");

    done_leaves: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (state_i == nebula_pkg::DEC_DONE) |=> (state_i != nebula_pkg::DEC_DONE))
        else $error("Decoder FSM stayed in DEC_DONE");

endmodule

bind wishbone_decoder nebula_sva sva0 (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_ack_i (wbs_ack_o),
    .state_i   (state_q),
    .strobes_i ({team_bus.stb, la_bus.stb, gpio_bus.stb, sram_bus.stb})
);

// File: testbench/nebula_tb.sv
`timescale 1ns/1ps
/* Testbench for nebula_top. Builds a table of Wishbone accesses and pad/LA checks,
   applies it in a loop and compares against values worked out from the address map. */
module nebula_tb;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_PADS,
        OP_LA
    } op_e;

    localparam int ACK_TIMEOUT = 20;  // Cycles allowed per access
    localparam int SRAM_WORDS  = 8;

    logic         clk;
    logic         rst;
    logic         cyc;
    logic         stb;
    logic         we;
    logic [3:0]   sel;
    logic [31:0]  adr;
    logic [31:0]  dat_w;
    logic         ack;
    logic [31:0]  dat_r;
    logic [127:0] la_in;
    logic [127:0] la_out;
    logic [37:0]  io_in;
    logic [37:0]  io_out;
    logic [37:0]  io_oeb;
    logic [31:0]  rdata;

    // Stimulus table, one entry per index
    string        t_name[$];
    op_e          t_op[$];
    logic [31:0]  t_adr[$];
    logic [31:0]  t_dat[$];
    logic [3:0]   t_sel[$];
    logic [127:0] t_exp[$];

    nebula_top dut0 (
        .wb_clk_i      (clk),
        .reset_i       (rst),
        .wbs_cyc_i     (cyc),
        .wbs_stb_i     (stb),
        .wbs_we_i      (we),
        .wbs_sel_i     (sel),
        .wbs_adr_i     (adr),
        .wbs_dat_i     (dat_w),
        .wbs_ack_o     (ack),
        .wbs_dat_o     (dat_r),
        .la_data_in_i  (la_in),
        .la_data_out_o (la_out),
        .io_in_i       (io_in),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb)
    );

    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] region_adr(input nebula_pkg::periph_e p,
                                               input logic [15:0] off);
        logic [2:0] code;
        code = p;
        return {nebula_pkg::USER_BASE, 6'b0, code[1:0], off};
    endfunction

    function automatic logic [31:0] sram_word(input int idx);
        return region_adr(nebula_pkg::PERIPH_SRAM, 16'((idx * 131 % 1024) * 4));
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  lanes);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // Packed as {oeb, out} so one compare covers both pad vectors
    function automatic logic [127:0] team_pads(input logic [31:0] pattern,
                                               input logic [31:0] oeb);
        return {52'b0, oeb, 6'h3f, pattern, 6'h00};
    endfunction

    task automatic add(input string name, input op_e op, input logic [31:0] a,
                       input logic [31:0] d, input logic [3:0] s, input logic [127:0] e);
        t_name.push_back(name);
        t_op.push_back(op);
        t_adr.push_back(a);
        t_dat.push_back(d);
        t_sel.push_back(s);
        t_exp.push_back(e);
    endtask

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        assert (got === exp) else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, got);
            stop_run();
        end
    endtask

    // One classic cycle, cyc/stb held until ack
    task automatic bus_cycle(input logic write, input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] s, output logic [31:0] rd);
        int waited;
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = a;
        dat_w = d;
        sel   = s;
        for (waited = 0; waited < ACK_TIMEOUT && !ack; waited++)
            @(negedge clk);
        if (!ack) begin
            $display("No ack within %0d cycles for the access at address %h", ACK_TIMEOUT, a);
            stop_run();
        end
        rd = dat_r;
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic settle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic build_table();
        logic [31:0] model [SRAM_WORDS];
        logic [31:0] word;
        logic [3:0]  lanes;
        logic [31:0] pattern;
        logic [31:0] oeb;
        logic [31:0] mask;
        logic [31:0] gpio_sel;
        logic [31:0] la_sel;
        logic [31:0] team;
        logic [127:0] idle_pads;

        gpio_sel  = region_adr(nebula_pkg::PERIPH_GPIO, 16'h0);
        la_sel    = region_adr(nebula_pkg::PERIPH_LA, 16'h0);
        team      = region_adr(nebula_pkg::PERIPH_TEAM, 16'h0);
        idle_pads = {52'b0, {38{1'b1}}, 38'h0};
        add("reset_pads", OP_PADS, 32'h0, 32'h0, 4'h0, idle_pads);
        add("reset_la", OP_LA, 32'h0, 32'h0, 4'h0, 128'h0);

        for (int i = 0; i < SRAM_WORDS; i++) begin
            model[i] = $urandom;
            add("sram_fill", OP_WRITE, sram_word(i), model[i], 4'hf, 128'h0);
        end
        for (int i = 0; i < SRAM_WORDS; i++) begin
            lanes    = 4'($urandom_range(14, 1));  // Partial lanes only
            word     = $urandom;
            model[i] = merge_bytes(model[i], word, lanes);
            add("sram_merge", OP_WRITE, sram_word(i), word, lanes, 128'h0);
        end
        for (int i = 0; i < SRAM_WORDS; i++)
            add("sram_read", OP_READ, sram_word(i), 32'h0, 4'hf, {96'b0, model[i]});

        pattern = $urandom;
        oeb     = $urandom;
        add("team_pattern", OP_WRITE, team, pattern, 4'hf, 128'h0);
        add("team_oeb", OP_WRITE, team + 32'd4, oeb, 4'hf, 128'h0);
        add("team_pattern_read", OP_READ, team, 32'h0, 4'hf, {96'b0, pattern});
        add("pads_unselected", OP_PADS, 32'h0, 32'h0, 4'h0, idle_pads);
        add("gpio_sel_team", OP_WRITE, gpio_sel, 32'd1, 4'hf, 128'h0);
        add("gpio_sel_read", OP_READ, gpio_sel, 32'h0, 4'hf, 128'd1);
        add("pads_team", OP_PADS, 32'h0, 32'h0, 4'h0, team_pads(pattern, oeb));
        add("gpio_sel_idle", OP_WRITE, gpio_sel, 32'd0, 4'hf, 128'h0);
        add("pads_idle", OP_PADS, 32'h0, 32'h0, 4'h0, idle_pads);
        add("gpio_sel_team_again", OP_WRITE, gpio_sel, 32'd1, 4'hf, 128'h0);
        add("pads_team_again", OP_PADS, 32'h0, 32'h0, 4'h0, team_pads(pattern, oeb));
        add("gpio_sel_range", OP_WRITE, gpio_sel, 32'd5, 4'hf, 128'h0);  // Past the last team
        add("gpio_sel_range_read", OP_READ, gpio_sel, 32'h0, 4'hf, 128'd5);
        add("pads_range", OP_PADS, 32'h0, 32'h0, 4'h0, idle_pads);

        mask = $urandom;
        add("team_mask", OP_WRITE, team + 32'd8, mask, 4'hf, 128'h0);
        add("la_sel_team", OP_WRITE, la_sel, 32'd1, 4'hf, 128'h0);
        add("la_sel_read", OP_READ, la_sel, 32'h0, 4'hf, 128'd1);
        add("la_team", OP_LA, 32'h0, 32'h0, 4'h0, la_in ^ {4{mask}});
        add("la_sel_idle", OP_WRITE, la_sel, 32'd0, 4'hf, 128'h0);
        add("la_idle", OP_LA, 32'h0, 32'h0, 4'h0, 128'h0);
        add("team_io_in", OP_READ, team + 32'd12, 32'h0, 4'hf, {96'b0, io_in[37:6]});

        // Top byte 0x31 is outside the user area, low bits alias SRAM word 0
        add("unmapped_write", OP_WRITE, 32'h3100_0000, 32'hdead_beef, 4'hf, 128'h0);
        add("unmapped_read", OP_READ, 32'h2000_0040, 32'h0, 4'hf, 128'h0);
        add("sram_after_unmapped", OP_READ, sram_word(0), 32'h0, 4'hf, {96'b0, model[0]});
    endtask

    initial begin
        void'($urandom(32'h72f8_d199));
        clk   = 1'b0;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        sel   = 4'h0;
        adr   = 32'h0;
        dat_w = 32'h0;
        la_in = {$urandom, $urandom, $urandom, $urandom};
        io_in = {$urandom, 6'($urandom)};
        build_table();

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        settle();
        check_value("reset_ack", 128'h0, {127'b0, ack});

        for (int i = 0; i < t_name.size(); i++) begin
            case (t_op[i])
                OP_WRITE: bus_cycle(1'b1, t_adr[i], t_dat[i], t_sel[i], rdata);
                OP_READ: begin
                    bus_cycle(1'b0, t_adr[i], t_dat[i], t_sel[i], rdata);
                    check_value(t_name[i], t_exp[i], {96'b0, rdata});
                end
                OP_PADS: begin
                    settle();
                    check_value(t_name[i], t_exp[i], {52'b0, io_oeb, io_out});
                end
                default: begin
                    settle();
                    check_value(t_name[i], t_exp[i], la_out);
                end
            endcase
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
